// File: audio_pkg.sv
// audio datapath types, imported by the sample buffer, the serializer and the top level
`default_nettype none

`include "periph_params.svh"

package audio_pkg;

	// one channel word, two's complement
	typedef logic signed [`PERIPH_AUDIO_DW-1:0] audio_sample_t;

	// position of the current bit inside a channel word
	// counts 0 up to word width minus one
	typedef logic [4:0] audio_bit_cnt_t;

endpackage

`default_nettype wire

// File: audio_sample_buffer.sv
// four-phase req/ack sample receiver with a one-entry stereo buffer feeding the i2s serializer
`timescale 1ns/100ps
`default_nettype none

module audio_sample_buffer (
	input wire clk,
	input wire reset,
	input wire sample_req_i,
	input wire audio_pkg::audio_sample_t sample_left_i,
	input wire audio_pkg::audio_sample_t sample_right_i,
	output logic sample_ack_o,
	input wire take_i,
	output logic pending_valid_o,
	output audio_pkg::audio_sample_t pending_left_o,
	output audio_pkg::audio_sample_t pending_right_o
);
	import audio_pkg::*;

	logic full_q;
	logic capture;

	// new handshake only with ack low and a free slot
	// a full buffer leaves ack low, host waits
	assign capture = sample_req_i & ~sample_ack_o & ~full_q;

	assign pending_valid_o = full_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			sample_ack_o <= 1'b0;
			full_q <= 1'b0;
		end else begin
			if (capture) begin
				sample_ack_o <= 1'b1;
			end else if (~sample_req_i) begin
				// req seen low, close the handshake
				sample_ack_o <= 1'b0;
			end

			// capture needs an empty slot so never collides with take
			if (capture) begin
				full_q <= 1'b1;
			end else if (take_i) begin
				full_q <= 1'b0;
			end
		end
	end

	// payload, qualified by full_q
	always_ff @(posedge clk) begin
		if (capture) begin
			pending_left_o <= sample_left_i;
			pending_right_o <= sample_right_i;
		end
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
audio_pkg.sv
joy_pkg.sv
i2s_clock_enable.sv
audio_sample_buffer.sv
i2s_serializer.sv
joy_shift_reader.sv
neptuno_periph_top.sv
tb_neptuno_periph.sv

// File: i2s_clock_enable.sv
// fractional divider making the i2s serial clock enable, instantiated in the peripheral top
`timescale 1ns/100ps
`default_nettype none

`include "periph_params.svh"

module i2s_clock_enable (
	input wire clk,
	input wire reset,
	output logic ce_o
);
	// two edges of sclk per bit, two channels per frame
	localparam logic [31:0] CE_STEP = 32'(`PERIPH_I2S_FREQ * 4 * `PERIPH_AUDIO_DW);

	logic [31:0] acc;
	logic [31:0] acc_next;

	assign acc_next = acc + CE_STEP;

	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
			ce_o <= 1'b0;
		end else if (acc_next >= `PERIPH_CLK_HZ) begin
			// wrap keeps the remainder, spacing averages out
			acc <= acc_next - `PERIPH_CLK_HZ;
			ce_o <= 1'b1;
		end else begin
			acc <= acc_next;
			ce_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: i2s_serializer.sv
// i2s frame generator driving sclk, lrclk and sdata from the buffered stereo sample
`timescale 1ns/100ps
`default_nettype none

`include "periph_params.svh"

module i2s_serializer (
	input wire clk,
	input wire reset,
	input wire ce_i,
	input wire pending_valid_i,
	input wire audio_pkg::audio_sample_t pending_left_i,
	input wire audio_pkg::audio_sample_t pending_right_i,
	output logic take_o,
	output logic i2s_sclk_o,
	output logic i2s_lrclk_o,
	output logic i2s_sdata_o
);
	import audio_pkg::*;

	localparam int DW = `PERIPH_AUDIO_DW;
	localparam audio_bit_cnt_t LAST_BIT = audio_bit_cnt_t'(DW - 1);

	audio_bit_cnt_t bit_cnt;
	audio_sample_t left_q;
	audio_sample_t right_q;
	audio_sample_t shift_q;
	audio_sample_t frame_left;
	audio_sample_t frame_right;
	logic fall;
	logic word_end;

	// sdata only moves on the falling sclk edge
	assign fall = ce_i & i2s_sclk_o;
	assign word_end = fall & (bit_cnt == LAST_BIT);

	// lrclk about to drop means frame start
	assign take_o = word_end & i2s_lrclk_o;

	// empty buffer repeats the last frame
	assign frame_left = pending_valid_i ? pending_left_i : left_q;
	assign frame_right = pending_valid_i ? pending_right_i : right_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			// last bit of a right word, so the first fall opens a frame
			bit_cnt <= LAST_BIT;
			i2s_sclk_o <= 1'b1;
			i2s_lrclk_o <= 1'b1;
			i2s_sdata_o <= 1'b1;
			// silence until the host delivers
			left_q <= '0;
			right_q <= '0;
		end else begin
			if (ce_i) begin
				i2s_sclk_o <= ~i2s_sclk_o;
			end

			if (word_end) begin
				bit_cnt <= '0;
				i2s_lrclk_o <= ~i2s_lrclk_o;
				if (i2s_lrclk_o) begin
					// left half, latch the whole frame now
					left_q <= frame_left;
					right_q <= frame_right;
					i2s_sdata_o <= frame_left[DW-1];
					shift_q <= frame_left << 1;
				end else begin
					i2s_sdata_o <= right_q[DW-1];
					shift_q <= right_q << 1;
				end
			end else if (fall) begin
				bit_cnt <= bit_cnt + 1'b1;
				i2s_sdata_o <= shift_q[DW-1];
				shift_q <= shift_q << 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: joy_pkg.sv
// joystick button types and scan word layout, imported by the joystick reader and top level
`default_nettype none

`include "periph_params.svh"

package joy_pkg;

	// one pad, fields in shift order, msb arrives first
	// active high once decoded
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
	} joy_buttons_t;

	// pad 1 shifts out ahead of pad 2
	typedef struct packed {
		joy_buttons_t joy1;
		joy_buttons_t joy2;
	} joy_pads_t;

	// same twelve bits seen two ways
	// raw is the shift word, oldest bit at the top
	typedef union packed {
		logic [`PERIPH_JOY_BITS-1:0] raw;
		joy_pads_t pads;
	} joy_scan_u;

endpackage

`default_nettype wire

// File: joy_shift_reader.sv
// serial reader for two 6-button joysticks behind an external load/clock/data shift chain
`timescale 1ns/100ps
`default_nettype none

`include "periph_params.svh"

module joy_shift_reader (
	input wire clk,
	input wire reset,
	input wire joy_data_i,
	output logic joy_clk_o,
	output logic joy_load_o,
	output logic joy_update_o,
	output joy_pkg::joy_buttons_t joy1_o,
	output joy_pkg::joy_buttons_t joy2_o
);
	import joy_pkg::*;

	localparam int DIV_W = $clog2(`PERIPH_JOY_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`PERIPH_JOY_DIV - 1);
	// phase 1 load low, 2 clock low, then rise on odd phases up to the last
	localparam logic [4:0] LAST_PHASE = 5'(2 * `PERIPH_JOY_BITS + 1);

	logic [DIV_W-1:0] div_cnt;
	logic half_tick;
	logic [4:0] phase;
	logic [4:0] phase_next;
	joy_scan_u scan_q;

	assign half_tick = (div_cnt == DIV_LAST);

	// phase 0 only follows reset, scans then run back to back
	assign phase_next = (phase == LAST_PHASE) ? 5'd1 : phase + 5'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
			phase <= '0;
			joy_clk_o <= 1'b1;
			joy_load_o <= 1'b1;
			joy_update_o <= 1'b0;
			joy1_o <= '0;
			joy2_o <= '0;
		end else begin
			joy_update_o <= 1'b0;
			div_cnt <= half_tick ? '0 : div_cnt + 1'b1;

			if (half_tick) begin
				phase <= phase_next;

				if (phase == LAST_PHASE) begin
					// chain is inverted, pressed reads low
					joy_update_o <= 1'b1;
					joy1_o <= ~scan_q.pads.joy1;
					joy2_o <= ~scan_q.pads.joy2;
				end

				if (phase_next == 5'd1) begin
					joy_load_o <= 1'b0;
				end else if (phase_next == 5'd2) begin
					joy_load_o <= 1'b1;
					joy_clk_o <= 1'b0;
				end else begin
					joy_clk_o <= phase_next[0];
				end
			end
		end
	end

	// bit present before the rising edge, chain shifts after it
	always_ff @(posedge clk) begin
		if (half_tick && phase_next[0] && phase_next != 5'd1) begin
			scan_q.raw <= {scan_q.raw[`PERIPH_JOY_BITS-2:0], joy_data_i};
		end
	end

endmodule

`default_nettype wire

// File: neptuno_periph_top.sv
// peripheral top level joining the i2s audio master and the joystick reader for the board
`timescale 1ns/100ps
`default_nettype none

module neptuno_periph_top (
	input wire clk,
	input wire reset,

	// host sample port, four-phase
	input wire sample_req_i,
	input wire audio_pkg::audio_sample_t sample_left_i,
	input wire audio_pkg::audio_sample_t sample_right_i,
	output logic sample_ack_o,

	// i2s pins
	output logic i2s_sclk_o,
	output logic i2s_lrclk_o,
	output logic i2s_sdata_o,

	// joystick chain pins
	input wire joy_data_i,
	output logic joy_clk_o,
	output logic joy_load_o,

	// decoded buttons
	output logic joy_update_o,
	output joy_pkg::joy_buttons_t joy1_o,
	output joy_pkg::joy_buttons_t joy2_o
);
	import audio_pkg::*;

	logic ce;
	logic take;
	logic pending_valid;
	audio_sample_t pending_left;
	audio_sample_t pending_right;

	i2s_clock_enable i_i2s_clock_enable (
		.clk (clk),
		.reset (reset),
		.ce_o (ce)
	);

	audio_sample_buffer i_audio_sample_buffer (
		.clk (clk),
		.reset (reset),
		.sample_req_i (sample_req_i),
		.sample_left_i (sample_left_i),
		.sample_right_i (sample_right_i),
		.sample_ack_o (sample_ack_o),
		.take_i (take),
		.pending_valid_o (pending_valid),
		.pending_left_o (pending_left),
		.pending_right_o (pending_right)
	);

	i2s_serializer i_i2s_serializer (
		.clk (clk),
		.reset (reset),
		.ce_i (ce),
		.pending_valid_i (pending_valid),
		.pending_left_i (pending_left),
		.pending_right_i (pending_right),
		.take_o (take),
		.i2s_sclk_o (i2s_sclk_o),
		.i2s_lrclk_o (i2s_lrclk_o),
		.i2s_sdata_o (i2s_sdata_o)
	);

	joy_shift_reader i_joy_shift_reader (
		.clk (clk),
		.reset (reset),
		.joy_data_i (joy_data_i),
		.joy_clk_o (joy_clk_o),
		.joy_load_o (joy_load_o),
		.joy_update_o (joy_update_o),
		.joy1_o (joy1_o),
		.joy2_o (joy2_o)
	);

endmodule

`default_nettype wire

// File: periph_params.svh
// build constants shared by the audio and joystick blocks, included by packages and RTL
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// system clock in hz
// the i2s divider compares its 32 bit accumulator against this
`define PERIPH_CLK_HZ 32'd27_000_000

// audio sample rate in hz
`define PERIPH_I2S_FREQ 48_000

// bits per channel word
// the bit counter in audio_pkg is sized for up to 31
`define PERIPH_AUDIO_DW 16

// length of the joystick scan chain
// two pads of six buttons each
`define PERIPH_JOY_BITS 12

// system cycles per half period of joystick clock
`define PERIPH_JOY_DIV 4

`endif

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" && \
	verilator --binary --timing -Wno-fatal -f filelist.f \
		--top-module tb_neptuno_periph -o sim_tb && \
	./obj_dir/sim_tb || exit 1

// File: tb_neptuno_periph.sv
// self-checking testbench driving the peripheral top with random audio and joystick stimulus
`timescale 1ns/100ps
`default_nettype none

`include "periph_params.svh"

module tb_neptuno_periph;
	import audio_pkg::*;
	import joy_pkg::*;

	localparam logic [31:0] SEED = 32'hb053;
	localparam int NUM_SAMPLES = 24;
	localparam int DW = `PERIPH_AUDIO_DW;
	localparam int MAX_GAP = 1023;
	// burst range with no idle gaps keeps the buffer full
	localparam int BURST_FIRST = 8;
	localparam int BURST_LAST = 15;
	localparam int FRAME_CYCLES = `PERIPH_CLK_HZ / `PERIPH_I2S_FREQ + 1;
	// worst case per sample is one gap plus one frame
	// four extra frames to drain and a factor of two margin
	localparam int TIMEOUT_CYCLES = (NUM_SAMPLES + 4) * (FRAME_CYCLES + MAX_GAP) * 2;

	logic clk, reset;
	logic sample_req_i, sample_ack_o;
	audio_sample_t sample_left_i, sample_right_i;
	logic i2s_sclk_o, i2s_lrclk_o, i2s_sdata_o;
	logic joy_data_i, joy_clk_o, joy_load_o, joy_update_o;
	joy_buttons_t joy1_o, joy2_o;

	// model state
	logic [31:0] audio_rng, joy_rng;
	logic [`PERIPH_JOY_BITS-1:0] joy_pat, joy_chain;
	logic joy_clk_prev, joy_load_prev, sclk_prev, ack_prev, host_go;
	audio_sample_t acc_left[$], acc_right[$];
	audio_sample_t rx_left, rx_right, held_left, held_right;
	int rx_bits, rx_idx, joy_scans, cycles;

	neptuno_periph_top i_neptuno_periph_top (
		.clk (clk),
		.reset (reset),
		.sample_req_i (sample_req_i),
		.sample_left_i (sample_left_i),
		.sample_right_i (sample_right_i),
		.sample_ack_o (sample_ack_o),
		.i2s_sclk_o (i2s_sclk_o),
		.i2s_lrclk_o (i2s_lrclk_o),
		.i2s_sdata_o (i2s_sdata_o),
		.joy_data_i (joy_data_i),
		.joy_clk_o (joy_clk_o),
		.joy_load_o (joy_load_o),
		.joy_update_o (joy_update_o),
		.joy1_o (joy1_o),
		.joy2_o (joy2_o)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// six bits in arrival order with up first
	// chain is active low so each bit is inverted
	function automatic joy_buttons_t pad_from_bits(input logic [5:0] bits);
		joy_buttons_t pad;
		pad.up = ~bits[5];
		pad.down = ~bits[4];
		pad.left = ~bits[3];
		pad.right = ~bits[2];
		pad.fire1 = ~bits[1];
		pad.fire2 = ~bits[0];
		return pad;
	endfunction

	task automatic stop_on_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic report_error(input string what);
		$display("ERROR at %0t: %s", $time, what);
		stop_on_failure();
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_sample(input string name, input audio_sample_t got,
			input audio_sample_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_pad(input string name, input joy_buttons_t got, input joy_buttons_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	// frame is either the next accepted sample or a repeat of the held one
	task automatic check_frame();
		if (rx_idx < acc_left.size() && rx_left == acc_left[rx_idx]
				&& rx_right == acc_right[rx_idx]) begin
			held_left = rx_left;
			held_right = rx_right;
			rx_idx++;
		end else begin
			check_sample("i2s left word", rx_left, held_left);
			check_sample("i2s right word", rx_right, held_right);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		sample_req_i = 1'b0;
		sample_left_i = '0;
		sample_right_i = '0;
		joy_data_i = 1'b1;
		audio_rng = SEED;
		joy_rng = ~SEED;
		joy_pat = '0;
		joy_chain = '1;
		joy_clk_prev = 1'b1;
		joy_load_prev = 1'b1;
		sclk_prev = 1'b1;
		ack_prev = 1'b0;
		host_go = 1'b0;
		held_left = '0;
		held_right = '0;
		rx_left = '0;
		rx_right = '0;
		rx_bits = 0;
		rx_idx = 0;
		joy_scans = 0;
		cycles = 0;
		repeat (10) @(negedge clk);
		// still in the last reset cycle with every port idle
		check_bit("sample_ack_o", sample_ack_o, 1'b0);
		check_bit("i2s_sclk_o", i2s_sclk_o, 1'b1);
		check_bit("i2s_lrclk_o", i2s_lrclk_o, 1'b1);
		check_bit("i2s_sdata_o", i2s_sdata_o, 1'b1);
		check_bit("joy_load_o", joy_load_o, 1'b1);
		check_bit("joy_clk_o", joy_clk_o, 1'b1);
		check_bit("joy_update_o", joy_update_o, 1'b0);
		check_pad("joy1_o", joy1_o, '0);
		check_pad("joy2_o", joy2_o, '0);
		reset <= 1'b0;
		host_go = 1'b1;
		wait (rx_idx == NUM_SAMPLES);
		if (joy_scans > 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			report_error("run ended without any joystick update");
		end
	end

	// host side of the four-phase handshake
	initial begin : host
		int gap;
		wait (host_go);
		@(negedge clk);
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			audio_rng = lcg_next(audio_rng);
			sample_left_i <= audio_sample_t'(audio_rng[31:16]);
			audio_rng = lcg_next(audio_rng);
			sample_right_i <= audio_sample_t'(audio_rng[31:16]);
			sample_req_i <= 1'b1;
			@(negedge clk);
			while (!sample_ack_o) @(negedge clk);
			acc_left.push_back(sample_left_i);
			acc_right.push_back(sample_right_i);
			sample_req_i <= 1'b0;
			@(negedge clk);
			while (sample_ack_o) @(negedge clk);
			audio_rng = lcg_next(audio_rng);
			gap = (i >= BURST_FIRST && i <= BURST_LAST) ? 0 : int'(audio_rng[25:16]);
			repeat (gap) @(negedge clk);
		end
	end

	// external shift chain behind the joystick pins
	always @(negedge clk) begin
		if (!reset) begin
			if (joy_update_o) begin
				// update shares its edge with the next load
				// joy_pat still holds the pattern of the finished scan
				joy_scans++;
				check_pad("joy1_o", joy1_o, pad_from_bits(joy_pat[11:6]));
				check_pad("joy2_o", joy2_o, pad_from_bits(joy_pat[5:0]));
			end
			if (!joy_load_o) begin
				if (joy_load_prev) begin
					joy_rng = lcg_next(joy_rng);
					joy_pat = joy_rng[27:16];
				end
				joy_chain = joy_pat;
			end else if (joy_clk_o && !joy_clk_prev) begin
				joy_chain = {joy_chain[10:0], 1'b1};
			end
			joy_data_i <= joy_chain[11];
		end
		joy_load_prev = joy_load_o;
		joy_clk_prev = joy_clk_o;
	end

	// handshake monitor, i2s receiver and cycle limit
	always @(negedge clk) begin
		if (!reset) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				report_error("timeout, not every sample reached the i2s output");
			end
			// req read here is the value the DUT saw at the last rising edge
			if (sample_ack_o && !ack_prev && !sample_req_i) begin
				report_error("ack rose while req was low");
			end
			if (!sample_ack_o && ack_prev && sample_req_i) begin
				report_error("ack fell while req was still high");
			end
			if (i2s_sclk_o && !sclk_prev) begin
				// left word while lrclk is low and right word while high
				check_bit("i2s_lrclk_o", i2s_lrclk_o, rx_bits >= DW);
				if (rx_bits < DW) begin
					rx_left = {rx_left[DW-2:0], i2s_sdata_o};
				end else begin
					rx_right = {rx_right[DW-2:0], i2s_sdata_o};
				end
				rx_bits++;
				if (rx_bits == 2 * DW) begin
					rx_bits = 0;
					check_frame();
				end
			end
		end
		ack_prev = sample_ack_o;
		sclk_prev = i2s_sclk_o;
	end

endmodule

`default_nettype wire
